// ==== rtl/video_timing_pkg.sv ====
// dvi raster timing
`default_nettype none

package video_timing_pkg;

    // --------------------
    // chip codes
    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,  // ntsc, 65 cycle lines
        chip_6569r3   = 2'd1,  // pal
        chip_6567r56a = 2'd2,  // early ntsc, 64 cycle lines
        chip_6569r1   = 2'd3   // early pal
    } chip_t;

    localparam int H_WIDTH_BITS = 11;  // x is always doubled
    localparam int V_WIDTH_BITS = 10;  // y doubled up to 624 lines

    typedef logic [H_WIDTH_BITS-1:0] hcount_t;
    typedef logic [V_WIDTH_BITS-1:0] vcount_t;

    typedef struct packed {
        hcount_t max_width;  // last count of the shortened line
        hcount_t ha_sta;     // picture starts after this count
        hcount_t ha_end;     // last picture count
        hcount_t hs_sta;
        hcount_t hs_end;
        hcount_t x_offset;   // skew of the read address into the native line
    } h_timing_t;

    typedef struct packed {
        vcount_t va_end;     // first blank line
        vcount_t vs_sta;
        vcount_t vs_end;
        vcount_t va_sta;     // picture resumes here
        vcount_t max_height; // last line of the frame
    } v_timing_t;

    // --------------------
    // horizontal, doubled
    localparam h_timing_t H_PAL  = '{11'd944, 11'd192, 11'd924, 11'd0, 11'd128, 11'd38};
    localparam h_timing_t H_R8   = '{11'd844, 11'd96, 11'd812, 11'd0, 11'd64, 11'd136};
    localparam h_timing_t H_R56A = '{11'd831, 11'd96, 11'd800, 11'd0, 11'd64, 11'd142};

    // vertical, native lines
    localparam v_timing_t V_PAL  = '{10'd300, 10'd301, 10'd309, 10'd310, 10'd311};
    localparam v_timing_t V_R8   = '{10'd13, 10'd14, 10'd22, 10'd23, 10'd262};
    localparam v_timing_t V_R56A = '{10'd13, 10'd14, 10'd22, 10'd23, 10'd261};

    function automatic h_timing_t h_timing(input chip_t chip);
        case (chip)
            chip_6569r1, chip_6569r3: return H_PAL;
            chip_6567r8:              return H_R8;
            default:                  return H_R56A;
        endcase
    endfunction

    // boundaries doubled unless the output runs at native y
    function automatic v_timing_t v_timing(input chip_t chip, input logic native_y);
        v_timing_t t;
        case (chip)
            chip_6569r1, chip_6569r3: t = V_PAL;
            chip_6567r8:              t = V_R8;
            default:                  t = V_R56A;
        endcase
        if (!native_y) begin
            t.va_end     = {t.va_end[V_WIDTH_BITS-2:0], 1'b0};
            t.vs_sta     = {t.vs_sta[V_WIDTH_BITS-2:0], 1'b0};
            t.vs_end     = {t.vs_end[V_WIDTH_BITS-2:0], 1'b0};
            t.va_sta     = {t.va_sta[V_WIDTH_BITS-2:0], 1'b0};
            t.max_height = {t.max_height[V_WIDTH_BITS-2:0], 1'b1};  // 2n - 1
        end
        return t;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/pixel_pkg.sv ====
// pixel and line buffer sizes
`default_nettype none

package pixel_pkg;
    import video_timing_pkg::*;

    localparam int COLOR_BITS   = 4;   // palette index
    localparam int LB_ADDR_BITS = 11;  // longest native line is 1040

    typedef logic [COLOR_BITS-1:0] color_t;
    typedef logic [LB_ADDR_BITS-1:0] lb_addr_t;

    // --------------------
    // native line length, dot rate doubled
    function automatic lb_addr_t line_words(input chip_t chip);
        case (chip)
            chip_6569r1, chip_6569r3: return 11'd1008;  // 504 x 2
            chip_6567r8:              return 11'd1040;  // 520 x 2
            default:                  return 11'd1024;  // 512 x 2
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== rtl/raster_counter.sv ====
// output raster counter
`default_nettype none

module raster_counter import video_timing_pkg::*; (
    input  wire                     clk_dvi,
    input  wire                     rst,        // active low
    input  wire chip_t              chip,
    input  wire                     native_y,   // one output line per native line
    output logic [H_WIDTH_BITS-1:0] h_count,
    output logic [V_WIDTH_BITS-1:0] v_count,
    output logic                    line_wrap   // advance from max_width to 0
);

    h_timing_t  ht;       // line length for this chip
    v_timing_t  vt;       // frame height, doubled or not
    logic [1:0] pace;     // free running sub count
    logic       advance;  // counters step this cycle

    assign ht = h_timing(chip);
    assign vt = v_timing(chip, native_y);

    // --------------------
    // pace divider

    // doubled y steps every cycle
    // native y only on odd pace values, so a line takes twice as long
    // and the frame rate stays the same
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            pace <= 2'b00;
        end else begin
            pace <= pace + 2'b01;
        end
    end

    assign advance = !native_y || (pace == 2'b01) || (pace == 2'b11);

    // last count of the line, only while stepping
    assign line_wrap = advance && (h_count >= ht.max_width);

    // --------------------
    // horizontal and vertical counters
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            h_count <= '0;
            v_count <= '0;
        end else if (advance) begin
            if (line_wrap) begin
                h_count <= '0;  // back to the sync edge
                if (v_count >= vt.max_height) begin
                    v_count <= '0;  // new frame
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sync_decode.sv ====
// sync and active window decoder
`default_nettype none

module sync_decode import video_timing_pkg::*; (
    input  wire                     clk_dvi,
    input  wire                     rst,           // active low
    input  wire chip_t              chip,
    input  wire                     native_y,
    input  wire                     hpolarity,     // 1 = active high
    input  wire                     vpolarity,
    input  wire                     enable_csync,  // composite sync on hsync
    input  wire [H_WIDTH_BITS-1:0]  h_count,
    input  wire [V_WIDTH_BITS-1:0]  v_count,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    active
);

    h_timing_t ht;
    v_timing_t vt;
    logic      hs_ah, vs_ah, cs_ah;   // pulses, active high
    logic      vblank;                // inside the vertical blank
    logic      hs_lvl, vs_lvl;        // pin levels after polarity and csync
    logic      hs_idle, vs_idle;      // levels while no pulse
    logic      hs_d, vs_d, act_d;     // first register stage

    assign ht = h_timing(chip);
    assign vt = v_timing(chip, native_y);

    // --------------------
    // pulse decode
    assign hs_ah = (h_count >= ht.hs_sta) && (h_count < ht.hs_end);
    // vertical pulse starts and stops on the hsync edge
    assign vs_ah = ((v_count == vt.vs_sta && h_count >= ht.hs_sta) || v_count > vt.vs_sta) &&
                   ((v_count == vt.vs_end && h_count < ht.hs_end) || v_count < vt.vs_end);
    assign cs_ah = hs_ah | vs_ah;

    // blank runs from va_end up to ha_sta of va_sta
    assign vblank = (v_count >= vt.va_end) &&
                    ((v_count == vt.va_sta && h_count < ht.ha_sta) || v_count < vt.va_sta);

    assign hs_lvl  = enable_csync ? (hpolarity ? cs_ah : ~cs_ah)  // csync follows hpolarity
                                  : (hpolarity ? hs_ah : ~hs_ah);
    assign vs_lvl  = enable_csync ? 1'b0 : (vpolarity ? vs_ah : ~vs_ah);
    assign hs_idle = ~hpolarity;
    assign vs_idle = enable_csync ? 1'b0 : ~vpolarity;

    // --------------------
    // two stages, matches ram read plus output reg in the line buffer
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            hs_d   <= hs_idle;
            vs_d   <= vs_idle;
            act_d  <= 1'b0;
            hsync  <= hs_idle;
            vsync  <= vs_idle;
            active <= 1'b0;
        end else begin
            hs_d   <= hs_lvl;
            vs_d   <= vs_lvl;
            act_d  <= (h_count > ht.ha_sta) && (h_count <= ht.ha_end) && !vblank;
            hsync  <= hs_d;
            vsync  <= vs_d;
            active <= act_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/line_buffer.sv ====
// double buffered line store
`default_nettype none

module line_buffer
    import video_timing_pkg::*;
    import pixel_pkg::*;
(
    input  wire                     clk_dvi,
    input  wire                     rst,          // active low
    input  wire chip_t              chip,
    input  wire                     native_y,
    input  wire [H_WIDTH_BITS-1:0]  h_count,
    input  wire [V_WIDTH_BITS-1:0]  v_count,
    input  wire                     line_wrap,    // end of output line
    input  wire                     pixel_valid,
    input  wire [COLOR_BITS-1:0]    pixel_color,
    output logic                    pixel_ready,
    output logic [COLOR_BITS-1:0]   color_out
);

    color_t    mem0 [2**LB_ADDR_BITS];  // bank 0
    color_t    mem1 [2**LB_ADDR_BITS];  // bank 1
    h_timing_t ht;
    lb_addr_t  last_word;  // index of the final pixel of a native line
    lb_addr_t  wr_addr;    // next slot in the write bank
    lb_addr_t  rd_addr;
    logic      full;       // write bank holds a whole line
    logic      wr_sel;     // bank being written, reader uses the other
    logic      rd_sel;     // read bank, aligned with the ram data
    logic      take;       // pixel accepted this cycle
    logic      swap;
    color_t    dout0, dout1;

    assign ht        = h_timing(chip);
    assign last_word = line_words(chip) - 1'b1;

    // --------------------
    // stream side
    assign pixel_ready = !full;  // independent of valid
    assign take        = pixel_valid && !full;

    // doubled mode shows each line twice, so swap only after the odd copy
    assign swap = line_wrap && full && (native_y || v_count[0]);

    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            wr_addr <= '0;
            full    <= 1'b0;
            wr_sel  <= 1'b0;
        end else if (swap) begin
            wr_addr <= '0;       // start the next native line
            full    <= 1'b0;
            wr_sel  <= ~wr_sel;
        end else if (take) begin
            wr_addr <= wr_addr + 1'b1;
            if (wr_addr == last_word) begin
                full <= 1'b1;    // ready drops next cycle
            end
        end
    end

    // --------------------
    // banks, write at wr_addr and read at the skewed count
    assign rd_addr = lb_addr_t'(h_count + ht.x_offset);

    always_ff @(posedge clk_dvi) begin
        if (take && !wr_sel) begin
            mem0[wr_addr] <= pixel_color;
        end
        dout0 <= mem0[rd_addr];
    end

    always_ff @(posedge clk_dvi) begin
        if (take && wr_sel) begin
            mem1[wr_addr] <= pixel_color;
        end
        dout1 <= mem1[rd_addr];
    end

    // bank choice follows the data through the ram stage
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            rd_sel <= 1'b1;
        end else begin
            rd_sel <= ~wr_sel;
        end
    end

    // output register, second stage
    always_ff @(posedge clk_dvi) begin
        color_out <= rd_sel ? dout1 : dout0;
    end

endmodule

`default_nettype wire

// ==== rtl/dvi_sync_top.sv ====
// dvi sync and line doubler
`default_nettype none

module dvi_sync_top
    import video_timing_pkg::*;
    import pixel_pkg::*;
(
    input  wire                    clk_dvi,
    input  wire                    rst,           // active low, sync
    input  wire chip_t             chip,          // static while running
    input  wire                    native_y,
    input  wire                    hpolarity,
    input  wire                    vpolarity,
    input  wire                    enable_csync,
    input  wire                    pixel_valid,   // native pixel stream
    input  wire [COLOR_BITS-1:0]   pixel_color,
    output logic                   pixel_ready,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   active,
    output logic [COLOR_BITS-1:0]  color_out
);

    logic [H_WIDTH_BITS-1:0] h_count;
    logic [V_WIDTH_BITS-1:0] v_count;
    logic                    line_wrap;

    // --------------------
    // counter, then decode and buffer side by side
    raster_counter raster_counter_i (
        .clk_dvi   (clk_dvi),
        .rst       (rst),
        .chip      (chip),
        .native_y  (native_y),
        .h_count   (h_count),
        .v_count   (v_count),
        .line_wrap (line_wrap)
    );

    sync_decode sync_decode_i (
        .clk_dvi      (clk_dvi),
        .rst          (rst),
        .chip         (chip),
        .native_y     (native_y),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .h_count      (h_count),
        .v_count      (v_count),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active)
    );

    line_buffer line_buffer_i (
        .clk_dvi     (clk_dvi),
        .rst         (rst),
        .chip        (chip),
        .native_y    (native_y),
        .h_count     (h_count),
        .v_count     (v_count),
        .line_wrap   (line_wrap),
        .pixel_valid (pixel_valid),
        .pixel_color (pixel_color),
        .pixel_ready (pixel_ready),
        .color_out   (color_out)      // same 2 cycle lag as the syncs
    );

endmodule

`default_nettype wire

// ==== tb/dvi_sync_properties.sv ====
// dvi sync assertions
`default_nettype none

module dvi_sync_properties import pixel_pkg::*; (
    input wire                  clk_dvi,
    input wire                  rst,
    input wire                  hpolarity,
    input wire                  enable_csync,
    input wire                  pixel_valid,
    input wire [COLOR_BITS-1:0] pixel_color,
    input wire                  pixel_ready,
    input wire                  hsync,
    input wire                  vsync,
    input wire                  active
);

    timeunit 1ns;
    timeprecision 1ps;

    // a pending pixel waits unchanged
    hold_pixel: assert property (@(posedge clk_dvi) disable iff (!rst)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_color))
        else $error("stream pixel dropped or changed before it was taken");

    csync_vsync_low: assert property (@(posedge clk_dvi) disable iff (!rst)
        enable_csync |-> !vsync)
        else $error("vsync moved while csync enabled");

    // picture never overlaps the sync pulse
    no_active_in_sync: assert property (@(posedge clk_dvi) disable iff (!rst)
        !(active && hsync == hpolarity))
        else $error("active during hsync");

endmodule

`default_nettype wire

// ==== tb/dvi_sync_checker.sv ====
// dvi output monitor
`default_nettype none

module dvi_sync_checker import video_timing_pkg::*; import pixel_pkg::*; (
    input  wire                   clk_dvi,
    input  wire                   rst,
    input  wire chip_t            chip,
    input  wire                   native_y,
    input  wire                   hpolarity,
    input  wire                   vpolarity,
    input  wire                   enable_csync,
    input  wire                   pixel_ready,
    input  wire                   hsync,
    input  wire                   vsync,
    input  wire                   active,
    input  wire [COLOR_BITS-1:0]  color_out,
    output int                    errors,
    output int                    blanks_seen,
    output int                    vsyncs_seen
);

    timeunit 1ns;
    timeprecision 1ps;

    h_timing_t ht;
    v_timing_t vn;                    // native vertical table
    int   mult, vsc, period, run_len, gap_norm, gap_blank, vs_len, hs_len;
    int   cyc, hs_edge, vs_edge, act_start, act_end, line, tag, expect_c;
    logic rst_q, hs_q, vs_q, act_q, have_hs, have_vs, have_act;
    logic hs_on, vs_on;

    initial errors = 0;

    // --------------------
    // expected shapes in cycles
    always_comb begin
        ht        = h_timing(chip);
        vn        = v_timing(chip, 1'b1);
        mult      = native_y ? 2 : 1;              // cycles per count
        vsc       = native_y ? 1 : 2;              // output lines per native line
        period    = (int'(ht.max_width) + 1) * mult;
        run_len   = (int'(ht.ha_end) - int'(ht.ha_sta)) * mult;
        gap_norm  = period - run_len;
        gap_blank = gap_norm + (int'(vn.va_sta) - int'(vn.va_end)) * vsc * period;
        vs_len    = (int'(vn.vs_end) - int'(vn.vs_sta)) * vsc * period
                    + (int'(ht.hs_end) - int'(ht.hs_sta)) * mult;
        hs_len    = (int'(ht.hs_end) - int'(ht.hs_sta)) * mult;
    end

    always @(posedge clk_dvi) begin
        hs_on = (hsync == hpolarity);
        vs_on = (vsync == vpolarity);
        if (!rst) begin
            if (!rst_q && (active || !pixel_ready || hsync !== !hpolarity ||
                           vsync !== (enable_csync ? 1'b0 : !vpolarity))) begin
                errors++;
                $display("Error %0d ns: outputs not at reset state", $time);
            end
            cyc = 0;
            {hs_q, vs_q, act_q, have_hs, have_vs, have_act} = '0;
            blanks_seen = 0;
            vsyncs_seen = 0;
        end else begin
            if (enable_csync && vsync !== 1'b0) begin
                errors++;
                $display("Error %0d ns: vsync high with csync enabled", $time);
            end
            // hsync period and width only without csync
            if (!enable_csync) begin
                if (hs_on && !hs_q) begin
                    if (have_hs && cyc - hs_edge != period) begin
                        errors++;
                        $display("Error %0d ns: line period %0d, expected %0d",
                                 $time, cyc - hs_edge, period);
                    end
                    hs_edge = cyc;
                    have_hs = 1'b1;
                end
                if (!hs_on && hs_q && cyc - hs_edge != hs_len) begin
                    errors++;
                    $display("Error %0d ns: hsync width %0d, expected %0d",
                             $time, cyc - hs_edge, hs_len);
                end
                if (vs_on && !vs_q) begin
                    vs_edge = cyc;
                    have_vs = 1'b1;
                end
                if (!vs_on && vs_q && have_vs) begin
                    vsyncs_seen++;
                    if (cyc - vs_edge != vs_len) begin
                        errors++;
                        $display("Error %0d ns: vsync width %0d, expected %0d",
                                 $time, cyc - vs_edge, vs_len);
                    end
                end
            end
            // active runs and gaps
            if (active && !act_q) begin
                if (have_act && cyc - act_end == gap_blank) begin
                    blanks_seen++;
                end else if (have_act && cyc - act_end != gap_norm) begin
                    errors++;
                    $display("Error %0d ns: active gap %0d", $time, cyc - act_end);
                end
                act_start = cyc;
                line = (cyc - 2) / period;   // outputs lag the counter by 2
            end
            if (!active && act_q) begin
                if (cyc - act_start != run_len) begin
                    errors++;
                    $display("Error %0d ns: active run %0d, expected %0d",
                             $time, cyc - act_start, run_len);
                end
                act_end = cyc;
                have_act = 1'b1;
            end
            // picture content with native tag 0 on the first shown line
            if (active && line >= 2) begin
                tag = native_y ? line - 1 : line / 2 - 1;
                expect_c = (tag + (cyc - act_start) / mult + int'(ht.ha_sta) + 1
                            + int'(ht.x_offset)) & 15;
                if (int'(color_out) != expect_c) begin
                    errors++;
                    $display("Error %0d ns: color %0d, expected %0d on line %0d",
                             $time, color_out, expect_c, line);
                end
            end
            hs_q  = hs_on;
            vs_q  = vs_on;
            act_q = active;
            cyc++;
        end
        rst_q = rst;
    end

endmodule

`default_nettype wire

// ==== tb/tb_dvi_sync.sv ====
// dvi sync testbench
`default_nettype none

module tb_dvi_sync
    import video_timing_pkg::*;
    import pixel_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        chip_t chip;
        logic  native_y, hpolarity, vpolarity, enable_csync;
        logic  stall;      // random gaps in the stream
        logic  full;       // row covers a whole frame
        int    lines;      // output lines to run
    } row_t;

    localparam int NUM_ROWS = 6;

    logic clk_dvi = 1'b0;
    logic rst;
    chip_t chip;
    logic native_y, hpolarity, vpolarity, enable_csync, stall;
    logic pixel_valid = 1'b0;
    logic [COLOR_BITS-1:0] pixel_color = '0;
    logic pixel_ready, hsync, vsync, active;
    logic [COLOR_BITS-1:0] color_out;
    row_t rows [NUM_ROWS];
    int   errors, blanks_seen, vsyncs_seen;
    int   misses = 0;      // expected events that never showed
    int   cycles = 0;
    int   limit;
    int   seed = 13;
    int   wr_pos, line_tag;  // stream position, native line number

    always #5 clk_dvi = ~clk_dvi;

    dvi_sync_top dvi_sync_top_i (.*);

    dvi_sync_checker dvi_sync_checker_i (.*);

    bind dvi_sync_top dvi_sync_properties dvi_sync_properties_i (.*);

    // cycles per output line for a row
    function automatic int line_cycles(input row_t r);
        return (int'(h_timing(r.chip).max_width) + 1) * (r.native_y ? 2 : 1);
    endfunction

    // --------------------
    // stream driver sends color = address + line tag
    always @(posedge clk_dvi) begin
        if (!rst) begin
            pixel_valid <= 1'b0;
            wr_pos = 0;
            line_tag = 0;
        end else begin
            if (pixel_valid && pixel_ready) begin
                wr_pos = wr_pos + 1;
                if (wr_pos == int'(line_words(chip))) begin
                    wr_pos = 0;
                    line_tag = line_tag + 1;  // next native line
                end
            end
            if (!pixel_valid || pixel_ready) begin  // hold a pending pixel
                pixel_valid <= !(stall && (($random(seed) & 3) == 0));
                pixel_color <= COLOR_BITS'(wr_pos + line_tag);
            end
        end
    end

    // watchdog
    always @(posedge clk_dvi) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: run passed %0d cycles without finishing", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic run_row(input int i);
        @(posedge clk_dvi);
        rst          <= 1'b0;
        chip         <= rows[i].chip;
        native_y     <= rows[i].native_y;
        hpolarity    <= rows[i].hpolarity;
        vpolarity    <= rows[i].vpolarity;
        enable_csync <= rows[i].enable_csync;
        stall        <= rows[i].stall;
        repeat (16) @(posedge clk_dvi);
        rst <= 1'b1;
        repeat (rows[i].lines * line_cycles(rows[i])) @(posedge clk_dvi);
        @(negedge clk_dvi);  // checker counts settled
        if (rows[i].full && blanks_seen == 0) begin
            $display("Row %0d never showed a vertical blank", i);
            misses = misses + 1;
        end
        if (rows[i].full && !rows[i].enable_csync && vsyncs_seen == 0) begin
            $display("Row %0d never showed a vsync pulse", i);
            misses = misses + 1;
        end
    endtask

    initial begin
        //        chip           ny  hp  vp  cs  stl full lines
        rows[0] = '{chip_6569r3,   0, 1, 1, 0, 0, 1, 630};
        rows[1] = '{chip_6567r8,   1, 0, 0, 0, 1, 1, 264};
        rows[2] = '{chip_6567r56a, 0, 0, 1, 1, 1, 0, 8};
        rows[3] = '{chip_6569r1,   1, 1, 0, 1, 0, 0, 8};
        rows[4] = '{chip_6567r8,   0, 1, 1, 0, 1, 0, 8};
        rows[5] = '{chip_6569r3,   1, 0, 1, 0, 1, 0, 8};
        rst = 1'b0;
        chip = rows[0].chip;
        native_y = 1'b0;
        hpolarity = 1'b1;
        vpolarity = 1'b1;
        enable_csync = 1'b0;
        stall = 1'b0;
        limit = 1000;
        for (int i = 0; i < NUM_ROWS; i++) begin
            limit = limit + rows[i].lines * 2 * (int'(h_timing(rows[i].chip).max_width) + 1)
                    + 64;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("Closing: %0d checker errors, %0d missing events", errors, misses);
        if (errors == 0 && misses == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/video_timing_pkg.sv
rtl/pixel_pkg.sv
rtl/raster_counter.sv
rtl/sync_decode.sv
rtl/line_buffer.sv
rtl/dvi_sync_top.sv
tb/dvi_sync_properties.sv
tb/dvi_sync_checker.sv
tb/tb_dvi_sync.sv

// ==== Makefile ====
# Verilator build and run for the DVI sync testbench

VERILATOR ?= verilator
TOP       ?= tb_dvi_sync
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
